// File: source/rv32m_pkg.sv
package rv32m_pkg;

  // RV32M funct3 codes handled by the multiply unit
  localparam logic [2:0] funct3_mul    = 3'b000;
  localparam logic [2:0] funct3_mulh   = 3'b001;
  localparam logic [2:0] funct3_mulhsu = 3'b010;
  localparam logic [2:0] funct3_mulhu  = 3'b011;

  // R-type OP opcode
  localparam logic [6:0] opcode_op = 7'b0110011;

  // funct7 that selects the M extension within OP
  localparam logic [6:0] funct7_muldiv = 7'b0000001;

  // sign mode of the multiplier operands
  // mul_su treats a as signed and b as unsigned
  typedef enum logic [1:0] {
    mul_uu = 2'b00,
    mul_ss = 2'b01,
    mul_su = 2'b10
  } mul_type_t;

  // default sizes of the unit
  // rs depth is log2 of the station entries, rob depth is the tag width
  localparam int default_rs_depth  = 3;
  localparam int default_rob_depth = 3;
  localparam int default_cdb_size  = 2;

endpackage

// File: source/shift_add_multiplier.sv
`timescale 1ns/1ps

module shift_add_multiplier (
  input  logic                  clk,
  input  logic                  rst,
  input  logic                  start,
  input  rv32m_pkg::mul_type_t  mul_type,
  input  logic [31:0]           a,
  input  logic [31:0]           b,
  output logic                  busy,
  output logic                  done,
  output logic [63:0]           p
);

  // operand sign handling
  logic        a_signed;
  logic        b_signed;
  logic        a_neg;
  logic        b_neg;
  logic [31:0] a_mag;
  logic [31:0] b_mag;

  // iteration state
  logic        busy_q;
  logic        done_q;
  logic [4:0]  step;
  logic        neg;
  logic        load;
  logic        last_step;

  // datapath registers
  logic [63:0] mcand;
  logic [31:0] mplier;
  logic [63:0] acc;
  logic [63:0] partial;
  logic [63:0] p_q;

  assign a_signed = (mul_type == rv32m_pkg::mul_ss) || (mul_type == rv32m_pkg::mul_su);
  assign b_signed = (mul_type == rv32m_pkg::mul_ss);

  assign a_neg = a_signed && a[31];
  assign b_neg = b_signed && b[31];

  // two's complement of 32'h8000_0000 still reads as 2^31 unsigned
  assign a_mag = a_neg ? (~a + 32'd1) : a;
  assign b_mag = b_neg ? (~b + 32'd1) : b;

  // a new operation is only taken while idle
  assign load      = start && !busy_q && !done_q;
  assign last_step = busy_q && (step == 5'd31);

  // one add of the shifted multiplicand per multiplier bit
  assign partial = acc + (mplier[0] ? mcand : 64'd0);

  always_ff @(posedge clk) begin
    if (rst) begin
      busy_q <= 1'b0;
      done_q <= 1'b0;
      step   <= '0;
      neg    <= 1'b0;
    end else begin
      done_q <= 1'b0;
      if (load) begin
        busy_q <= 1'b1;
        step   <= '0;
        neg    <= a_neg ^ b_neg;
      end else if (busy_q) begin
        step <= step + 5'd1;
        if (last_step) begin
          busy_q <= 1'b0;
          done_q <= 1'b1;
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (load) begin
      mcand  <= {32'd0, a_mag};
      mplier <= b_mag;
      acc    <= '0;
    end else if (busy_q) begin
      acc    <= partial;
      mcand  <= mcand << 1;
      mplier <= mplier >> 1;
      // fold the result sign back in on the final step
      if (last_step) begin
        p_q <= neg ? (~partial + 64'd1) : partial;
      end
    end
  end

  assign busy = busy_q;
  assign done = done_q;

  // p only changes on the last step, so it is stable while done is high
  assign p = p_q;

endmodule

// File: source/mul_rs.sv
`timescale 1ns/1ps

module mul_rs #(
  parameter int MUL_RS_DEPTH = 3,
  parameter int ROB_DEPTH    = 3,
  parameter int CDB_SIZE     = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  output logic                  full,
  input  logic                  issue,

  input  logic [6:0]            opcode,
  input  logic [2:0]            funct3,
  input  logic [6:0]            funct7,
  input  logic [ROB_DEPTH-1:0]  issue_target_rob,

  // operand state from the register file and scoreboard
  input  logic                  rs1_regfile_ready,
  input  logic                  rs2_regfile_ready,
  input  logic [31:0]           rs1_regfile_v,
  input  logic [31:0]           rs2_regfile_v,
  input  logic [ROB_DEPTH-1:0]  rs1_regfile_rob,
  input  logic [ROB_DEPTH-1:0]  rs2_regfile_rob,

  // completed but not yet committed values
  input  logic                  rs1_rob_ready,
  input  logic                  rs2_rob_ready,
  input  logic [31:0]           rs1_rob_v,
  input  logic [31:0]           rs2_rob_v,

  input  logic                  cdb_valid [CDB_SIZE],
  input  logic [ROB_DEPTH-1:0]  cdb_rob   [CDB_SIZE],
  input  logic [31:0]           cdb_rd_v  [CDB_SIZE],

  output logic                  mul_valid,
  output logic [31:0]           mul_f,
  output logic [ROB_DEPTH-1:0]  mul_rob,

  output logic                  mul_start,
  output rv32m_pkg::mul_type_t  mul_type,
  output logic [31:0]           mul_a,
  output logic [31:0]           mul_b,
  input  logic                  mul_busy,
  input  logic                  mul_done,
  input  logic [63:0]           mul_p
);

  localparam int NUM_ENTRIES = 2 ** MUL_RS_DEPTH;

  // control state per entry
  logic                  entry_valid [NUM_ENTRIES];
  logic                  rs1_ready   [NUM_ENTRIES];
  logic                  rs2_ready   [NUM_ENTRIES];

  // payload per entry
  logic [31:0]           rs1_v       [NUM_ENTRIES];
  logic [31:0]           rs2_v       [NUM_ENTRIES];
  logic [ROB_DEPTH-1:0]  rs1_tag     [NUM_ENTRIES];
  logic [ROB_DEPTH-1:0]  rs2_tag     [NUM_ENTRIES];
  logic [ROB_DEPTH-1:0]  target_tag  [NUM_ENTRIES];
  logic [2:0]            funct3_q    [NUM_ENTRIES];

  // entry currently inside the multiplier
  logic                    exe_valid;
  logic [MUL_RS_DEPTH-1:0] exe_idx;

  logic                    issue_ok;
  logic                    free_found;
  logic [MUL_RS_DEPTH-1:0] free_idx;
  logic                    sel_found;
  logic [MUL_RS_DEPTH-1:0] sel_idx;

  // operand values captured at issue
  logic        cap1_ready;
  logic        cap2_ready;
  logic [31:0] cap1_v;
  logic [31:0] cap2_v;
  logic [32:0] issue_cdb1;
  logic [32:0] issue_cdb2;

  // wakeup of waiting operands, bit 32 is the hit flag
  logic [32:0] snoop1 [NUM_ENTRIES];
  logic [32:0] snoop2 [NUM_ENTRIES];
  logic        wake1  [NUM_ENTRIES];
  logic        wake2  [NUM_ENTRIES];

  // search every CDB port for a broadcast of tag
  function automatic logic [32:0] cdb_lookup(input logic [ROB_DEPTH-1:0] tag);
    logic [32:0] hit;
    hit = '0;
    for (int j = 0; j < CDB_SIZE; j++) begin
      if (cdb_valid[j] && (cdb_rob[j] == tag)) begin
        hit = {1'b1, cdb_rd_v[j]};
      end
    end
    return hit;
  endfunction

  // only M-extension OP instructions belong to this station
  assign issue_ok = issue && (opcode == rv32m_pkg::opcode_op) &&
                    (funct7 == rv32m_pkg::funct7_muldiv);

  // lowest free entry, and full when there is none
  always_comb begin
    free_found = 1'b0;
    free_idx   = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (!entry_valid[i]) begin
        free_found = 1'b1;
        free_idx   = MUL_RS_DEPTH'(i);
      end
    end
  end

  assign full = !free_found;

  // operand capture: regfile first, then ROB, then a same-cycle broadcast
  always_comb begin
    issue_cdb1 = cdb_lookup(rs1_regfile_rob);
    issue_cdb2 = cdb_lookup(rs2_regfile_rob);
    if (rs1_regfile_ready) begin
      cap1_ready = 1'b1;
      cap1_v     = rs1_regfile_v;
    end else if (rs1_rob_ready) begin
      cap1_ready = 1'b1;
      cap1_v     = rs1_rob_v;
    end else begin
      cap1_ready = issue_cdb1[32];
      cap1_v     = issue_cdb1[31:0];
    end
    if (rs2_regfile_ready) begin
      cap2_ready = 1'b1;
      cap2_v     = rs2_regfile_v;
    end else if (rs2_rob_ready) begin
      cap2_ready = 1'b1;
      cap2_v     = rs2_rob_v;
    end else begin
      cap2_ready = issue_cdb2[32];
      cap2_v     = issue_cdb2[31:0];
    end
  end

  always_comb begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      snoop1[i] = cdb_lookup(rs1_tag[i]);
      snoop2[i] = cdb_lookup(rs2_tag[i]);
      wake1[i]  = entry_valid[i] && !rs1_ready[i] && snoop1[i][32];
      wake2[i]  = entry_valid[i] && !rs2_ready[i] && snoop2[i][32];
    end
  end

  // lowest entry with both operands in hand
  always_comb begin
    sel_found = 1'b0;
    sel_idx   = '0;
    for (int i = NUM_ENTRIES - 1; i >= 0; i--) begin
      if (entry_valid[i] && rs1_ready[i] && rs2_ready[i] &&
          !(exe_valid && (exe_idx == MUL_RS_DEPTH'(i)))) begin
        sel_found = 1'b1;
        sel_idx   = MUL_RS_DEPTH'(i);
      end
    end
  end

  assign mul_start = sel_found && !exe_valid && !mul_busy && !mul_done;
  assign mul_a     = rs1_v[sel_idx];
  assign mul_b     = rs2_v[sel_idx];

  always_comb begin
    case (funct3_q[sel_idx])
      rv32m_pkg::funct3_mulh:   mul_type = rv32m_pkg::mul_ss;
      rv32m_pkg::funct3_mulhsu: mul_type = rv32m_pkg::mul_su;
      // MUL keeps the low half, which is the same for any sign mode
      default:                  mul_type = rv32m_pkg::mul_uu;
    endcase
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      exe_valid <= 1'b0;
      exe_idx   <= '0;
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        entry_valid[i] <= 1'b0;
        rs1_ready[i]   <= 1'b0;
        rs2_ready[i]   <= 1'b0;
      end
    end else begin
      for (int i = 0; i < NUM_ENTRIES; i++) begin
        if (wake1[i]) begin
          rs1_ready[i] <= 1'b1;
        end
        if (wake2[i]) begin
          rs2_ready[i] <= 1'b1;
        end
      end
      if (issue_ok && free_found) begin
        entry_valid[free_idx] <= 1'b1;
        rs1_ready[free_idx]   <= cap1_ready;
        rs2_ready[free_idx]   <= cap2_ready;
      end
      if (mul_start) begin
        exe_valid <= 1'b1;
        exe_idx   <= sel_idx;
      end
      // the result goes out this cycle, so the entry is released
      if (mul_done) begin
        exe_valid            <= 1'b0;
        entry_valid[exe_idx] <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      if (wake1[i]) begin
        rs1_v[i] <= snoop1[i][31:0];
      end
      if (wake2[i]) begin
        rs2_v[i] <= snoop2[i][31:0];
      end
    end
    if (issue_ok && free_found) begin
      rs1_v[free_idx]      <= cap1_v;
      rs2_v[free_idx]      <= cap2_v;
      rs1_tag[free_idx]    <= rs1_regfile_rob;
      rs2_tag[free_idx]    <= rs2_regfile_rob;
      target_tag[free_idx] <= issue_target_rob;
      funct3_q[free_idx]   <= funct3;
    end
  end

  // result formatting follows the executing entry's own funct3
  assign mul_valid = mul_done;
  assign mul_rob   = target_tag[exe_idx];
  assign mul_f     = (funct3_q[exe_idx] == rv32m_pkg::funct3_mul) ? mul_p[31:0] : mul_p[63:32];

endmodule

// File: source/mul_unit.sv
`timescale 1ns/1ps

module mul_unit #(
  parameter int MUL_RS_DEPTH = rv32m_pkg::default_rs_depth,
  parameter int ROB_DEPTH    = rv32m_pkg::default_rob_depth,
  parameter int CDB_SIZE     = rv32m_pkg::default_cdb_size
) (
  input  logic                  clk,
  input  logic                  rst,
  output logic                  full,
  input  logic                  issue,

  input  logic [6:0]            opcode,
  input  logic [2:0]            funct3,
  input  logic [6:0]            funct7,
  input  logic [ROB_DEPTH-1:0]  issue_target_rob,

  input  logic                  rs1_regfile_ready,
  input  logic                  rs2_regfile_ready,
  input  logic [31:0]           rs1_regfile_v,
  input  logic [31:0]           rs2_regfile_v,
  input  logic [ROB_DEPTH-1:0]  rs1_regfile_rob,
  input  logic [ROB_DEPTH-1:0]  rs2_regfile_rob,

  input  logic                  rs1_rob_ready,
  input  logic                  rs2_rob_ready,
  input  logic [31:0]           rs1_rob_v,
  input  logic [31:0]           rs2_rob_v,

  input  logic                  cdb_valid [CDB_SIZE],
  input  logic [ROB_DEPTH-1:0]  cdb_rob   [CDB_SIZE],
  input  logic [31:0]           cdb_rd_v  [CDB_SIZE],

  output logic                  mul_valid,
  output logic [31:0]           mul_f,
  output logic [ROB_DEPTH-1:0]  mul_rob
);

  // station to multiplier
  logic                  mul_start;
  rv32m_pkg::mul_type_t  mul_type;
  logic [31:0]           mul_a;
  logic [31:0]           mul_b;
  logic                  mul_busy;
  logic                  mul_done;
  logic [63:0]           mul_p;

  mul_rs #(
    .MUL_RS_DEPTH (MUL_RS_DEPTH),
    .ROB_DEPTH    (ROB_DEPTH),
    .CDB_SIZE     (CDB_SIZE)
  ) rs_i (
    .clk               (clk),
    .rst               (rst),
    .full              (full),
    .issue             (issue),
    .opcode            (opcode),
    .funct3            (funct3),
    .funct7            (funct7),
    .issue_target_rob  (issue_target_rob),
    .rs1_regfile_ready (rs1_regfile_ready),
    .rs2_regfile_ready (rs2_regfile_ready),
    .rs1_regfile_v     (rs1_regfile_v),
    .rs2_regfile_v     (rs2_regfile_v),
    .rs1_regfile_rob   (rs1_regfile_rob),
    .rs2_regfile_rob   (rs2_regfile_rob),
    .rs1_rob_ready     (rs1_rob_ready),
    .rs2_rob_ready     (rs2_rob_ready),
    .rs1_rob_v         (rs1_rob_v),
    .rs2_rob_v         (rs2_rob_v),
    .cdb_valid         (cdb_valid),
    .cdb_rob           (cdb_rob),
    .cdb_rd_v          (cdb_rd_v),
    .mul_valid         (mul_valid),
    .mul_f             (mul_f),
    .mul_rob           (mul_rob),
    .mul_start         (mul_start),
    .mul_type          (mul_type),
    .mul_a             (mul_a),
    .mul_b             (mul_b),
    .mul_busy          (mul_busy),
    .mul_done          (mul_done),
    .mul_p             (mul_p)
  );

  shift_add_multiplier mult_i (
    .clk      (clk),
    .rst      (rst),
    .start    (mul_start),
    .mul_type (mul_type),
    .a        (mul_a),
    .b        (mul_b),
    .busy     (mul_busy),
    .done     (mul_done),
    .p        (mul_p)
  );

endmodule

// File: tb/mul_unit_asserts.sv
`timescale 1ns/1ps

module mul_unit_asserts (
  input logic clk,
  input logic rst,
  input logic issue,
  input logic full,
  input logic mul_valid,
  input logic mul_start,
  input logic mul_busy
);

  // the issue stage holds off while the station is full
  assert property (@(posedge clk) disable iff (rst) full |-> !issue)
    else $error("issue asserted while the station is full");

  // each result is a single-cycle pulse
  assert property (@(posedge clk) disable iff (rst) mul_valid |=> !mul_valid)
    else $error("mul_valid high on two consecutive cycles");

  // new work only enters an idle multiplier and sets it busy
  assert property (@(posedge clk) disable iff (rst) mul_start |-> !mul_busy ##1 mul_busy)
    else $error("mul_start raised while the multiplier is busy or not taken by it");

endmodule

// File: tb/mul_unit_tb.sv
`timescale 1ns/1ps

module mul_unit_tb;

  localparam int RS_DEPTH    = rv32m_pkg::default_rs_depth;
  localparam int ROB_DEPTH   = rv32m_pkg::default_rob_depth;
  localparam int CDB_SIZE    = rv32m_pkg::default_cdb_size;
  localparam int NUM_TAGS    = 2 ** ROB_DEPTH;
  localparam int NUM_ENTRIES = 2 ** RS_DEPTH;
  localparam int NUM_RANDOM  = 200;
  // 12 single ops, 4 wakeup ops, one full station, then the random run
  localparam int NUM_OPS     = 12 + 4 + NUM_ENTRIES + NUM_RANDOM;
  localparam int MAX_CYCLES  = 2 * (NUM_OPS * 40) + 2000;

  logic                 clk = 1'b0;
  logic                 rst;
  logic                 full;
  logic                 issue;
  logic [6:0]           opcode;
  logic [2:0]           funct3;
  logic [6:0]           funct7;
  logic [ROB_DEPTH-1:0] issue_target_rob;
  logic                 rs1_regfile_ready;
  logic                 rs2_regfile_ready;
  logic [31:0]          rs1_regfile_v;
  logic [31:0]          rs2_regfile_v;
  logic [ROB_DEPTH-1:0] rs1_regfile_rob;
  logic [ROB_DEPTH-1:0] rs2_regfile_rob;
  logic                 rs1_rob_ready;
  logic                 rs2_rob_ready;
  logic [31:0]          rs1_rob_v;
  logic [31:0]          rs2_rob_v;
  logic                 cdb_valid [CDB_SIZE];
  logic [ROB_DEPTH-1:0] cdb_rob   [CDB_SIZE];
  logic [31:0]          cdb_rd_v  [CDB_SIZE];
  logic                 mul_valid;
  logic [31:0]          mul_f;
  logic [ROB_DEPTH-1:0] mul_rob;

  // scoreboard with one slot per destination tag
  logic [31:0] exp_val  [NUM_TAGS];
  int          exp_lat  [NUM_TAGS];
  int          issue_at [NUM_TAGS];
  int          n_sent   [NUM_TAGS];
  int          n_done   [NUM_TAGS];
  // value that a producer tag carries on its next broadcast
  logic [31:0] prod_v   [NUM_TAGS];
  int          cycle;

  mul_unit dut_i (.*);

  bind mul_rs mul_unit_asserts asserts_i (
    .clk       (clk),
    .rst       (rst),
    .issue     (issue),
    .full      (full),
    .mul_valid (mul_valid),
    .mul_start (mul_start),
    .mul_busy  (mul_busy)
  );

  always #4 clk = ~clk;

  function automatic logic [31:0] ref_result(input logic [2:0] f3, input logic [31:0] a,
                                             input logic [31:0] b);
    logic        a_sx;
    logic        b_sx;
    logic [63:0] prod;
    a_sx = (f3 == rv32m_pkg::funct3_mulh) || (f3 == rv32m_pkg::funct3_mulhsu);
    b_sx = (f3 == rv32m_pkg::funct3_mulh);
    // sign extension to 64 bits makes a plain product exact
    prod = {(a_sx ? {32{a[31]}} : 32'd0), a} * {(b_sx ? {32{b[31]}} : 32'd0), b};
    return (f3 == rv32m_pkg::funct3_mul) ? prod[31:0] : prod[63:32];
  endfunction

  function automatic bit pending(input int t);
    return n_sent[t] != n_done[t];
  endfunction

  function automatic int outstanding();
    int n;
    n = 0;
    for (int t = 0; t < NUM_TAGS; t++) begin
      n += int'(pending(t));
    end
    return n;
  endfunction

  task automatic abort_run();
    $display("*** FAILED ***");
    $fatal(1, "simulation stopped at cycle %0d", cycle);
  endtask

  task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
    if (got !== exp) begin
      $display("MISMATCH %s: got 0x%08h, expected 0x%08h", name, got, exp);
      abort_run();
    end
  endtask

  // src 0 is the regfile, 1 the ROB, 2 waits on the tag held in the low bits of v
  task automatic issue_op(input logic [2:0] f3, input logic [ROB_DEPTH-1:0] tgt, input int lat,
                          input int src1, input logic [31:0] v1,
                          input int src2, input logic [31:0] v2);
    logic [31:0] a;
    logic [31:0] b;
    a = (src1 == 2) ? prod_v[v1[ROB_DEPTH-1:0]] : v1;
    b = (src2 == 2) ? prod_v[v2[ROB_DEPTH-1:0]] : v2;
    issue = 1'b1;
    opcode = rv32m_pkg::opcode_op;
    funct7 = rv32m_pkg::funct7_muldiv;
    funct3 = f3;
    issue_target_rob = tgt;
    rs1_regfile_ready = (src1 == 0);
    rs2_regfile_ready = (src2 == 0);
    rs1_rob_ready = (src1 == 1);
    rs2_rob_ready = (src2 == 1);
    // unused sources carry noise
    rs1_regfile_v = (src1 == 0) ? v1 : $urandom;
    rs2_regfile_v = (src2 == 0) ? v2 : $urandom;
    rs1_rob_v = (src1 == 1) ? v1 : $urandom;
    rs2_rob_v = (src2 == 1) ? v2 : $urandom;
    rs1_regfile_rob = v1[ROB_DEPTH-1:0];
    rs2_regfile_rob = v2[ROB_DEPTH-1:0];
    exp_val[tgt] = ref_result(f3, a, b);
    exp_lat[tgt] = lat;
    issue_at[tgt] = cycle + 1;
    n_sent[tgt]++;
  endtask

  task automatic broadcast(input int port, input logic [ROB_DEPTH-1:0] tag);
    cdb_valid[port] = 1'b1;
    cdb_rob[port] = tag;
    cdb_rd_v[port] = prod_v[tag];
  endtask

  // a broadcast producer gets a fresh value for its next use of the tag
  task automatic step();
    @(negedge clk);
    for (int p = 0; p < CDB_SIZE; p++) begin
      if (cdb_valid[p]) begin
        prod_v[cdb_rob[p]] = $urandom;
      end
      cdb_valid[p] = 1'b0;
    end
    issue = 1'b0;
  endtask

  task automatic wait_drained();
    while (outstanding() != 0) begin
      step();
    end
  endtask

  task automatic test_reset_idle();
    repeat (10) begin
      check_value("full", 32'(full), 0);
      check_value("mul_valid", 32'(mul_valid), 0);
      step();
    end
  endtask

  task automatic test_each_op();
    logic [31:0] ca [3];
    logic [31:0] cb [3];
    ca[0] = 32'h8000_0000;
    cb[0] = 32'h8000_0000;
    ca[1] = 32'hffff_ffff;
    cb[1] = 32'h7fff_ffff;
    ca[2] = $urandom;
    cb[2] = $urandom;
    for (int f = 0; f < 4; f++) begin
      for (int k = 0; k < 3; k++) begin
        issue_op(3'(f), ROB_DEPTH'(k), 33, 0, ca[k], 0, cb[k]);
        step();
        wait_drained();
      end
    end
  endtask

  task automatic test_wakeup();
    issue_op(rv32m_pkg::funct3_mulh, 0, -1, 1, 32'hdead_beef, 1, 32'h1234_5678);
    step();
    issue_op(rv32m_pkg::funct3_mulhu, 1, -1, 1, $urandom, 0, $urandom);
    step();
    // late wakeup with one operand on each CDB port
    issue_op(rv32m_pkg::funct3_mulhsu, 2, -1, 2, 32'd5, 2, 32'd6);
    repeat (4) step();
    broadcast(0, 5);
    repeat (2) step();
    broadcast(1, 6);
    step();
    // producers broadcast in the issue cycle itself
    broadcast(1, 4);
    broadcast(0, 7);
    issue_op(rv32m_pkg::funct3_mul, 3, -1, 2, 32'd4, 2, 32'd7);
    step();
    wait_drained();
  endtask

  task automatic test_fill();
    for (int i = 0; i < NUM_ENTRIES; i++) begin
      check_value("full", 32'(full), 0);
      issue_op(3'(i % 4), ROB_DEPTH'(i), -1, 2, 32'(i), 0, $urandom);
      step();
    end
    check_value("full", 32'(full), 1);
    for (int i = 0; i < NUM_ENTRIES; i += 2) begin
      broadcast(0, ROB_DEPTH'(i));
      broadcast(1, ROB_DEPTH'(i + 1));
      step();
    end
    while (!mul_valid) begin
      check_value("full", 32'(full), 1);
      step();
    end
    step();
    check_value("full", 32'(full), 0);
    wait_drained();
  endtask

  task automatic test_random(input int count);
    int                   sent;
    bit                   found;
    logic [ROB_DEPTH-1:0] tgt;
    sent = 0;
    while (sent < count || outstanding() != 0) begin
      for (int p = 0; p < CDB_SIZE; p++) begin
        if ($urandom % 3 == 0) begin
          broadcast(p, ROB_DEPTH'($urandom));
        end
      end
      found = 1'b0;
      tgt = ROB_DEPTH'($urandom);
      // skip tags still outstanding or retiring in this very cycle
      for (int t = 0; t < NUM_TAGS && !found; t++) begin
        if (pending(int'(tgt)) || (mul_valid && mul_rob == tgt)) begin
          tgt = tgt + 1'b1;
        end else begin
          found = 1'b1;
        end
      end
      if (sent < count && found && !full && ($urandom % 4 != 0)) begin
        issue_op(3'($urandom % 4), tgt, -1, int'($urandom % 3), $urandom,
                 int'($urandom % 3), $urandom);
        sent++;
      end
      step();
    end
  endtask

  // every result taken from the CDB must carry an outstanding tag
  always @(negedge clk) begin
    if (!rst && mul_valid) begin
      if (!pending(int'(mul_rob))) begin
        $display("result with tag %0d arrived but no operation with that tag is open", mul_rob);
        abort_run();
      end else begin
        check_value("mul_f", mul_f, exp_val[mul_rob]);
        if (exp_lat[mul_rob] >= 0) begin
          check_value("mul_valid latency", 32'(cycle - issue_at[mul_rob]),
                      32'(exp_lat[mul_rob]));
        end
        n_done[mul_rob]++;
      end
    end
  end

  always @(posedge clk) begin
    cycle <= cycle + 1;
    if (cycle >= MAX_CYCLES) begin
      $display("timeout: run exceeded %0d cycles", MAX_CYCLES);
      abort_run();
    end
  end

  initial begin
    void'($urandom(32'hdf80_8579));
    rst = 1'b1;
    issue = 1'b0;
    opcode = '0;
    funct3 = '0;
    funct7 = '0;
    issue_target_rob = '0;
    rs1_regfile_ready = 1'b0;
    rs2_regfile_ready = 1'b0;
    rs1_regfile_v = '0;
    rs2_regfile_v = '0;
    rs1_regfile_rob = '0;
    rs2_regfile_rob = '0;
    rs1_rob_ready = 1'b0;
    rs2_rob_ready = 1'b0;
    rs1_rob_v = '0;
    rs2_rob_v = '0;
    for (int p = 0; p < CDB_SIZE; p++) begin
      cdb_valid[p] = 1'b0;
      cdb_rob[p] = '0;
      cdb_rd_v[p] = '0;
    end
    for (int t = 0; t < NUM_TAGS; t++) begin
      prod_v[t] = $urandom;
    end
    repeat (8) @(negedge clk);
    rst = 1'b0;
    test_reset_idle();
    test_each_op();
    test_wakeup();
    test_fill();
    test_random(NUM_RANDOM);
    if (outstanding() == 0) begin
      $display("*** PASSED ***");
      $finish;
    end else begin
      $display("operations still open at the end of the run");
      abort_run();
    end
  end

endmodule

// File: src.f
source/rv32m_pkg.sv
source/shift_add_multiplier.sv
source/mul_rs.sv
source/mul_unit.sv
tb/mul_unit_asserts.sv
tb/mul_unit_tb.sv

// File: run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert --timescale 1ns/1ps \
  --top-module mul_unit_tb -f src.f -Mdir obj_dir -o mul_unit_sim

./obj_dir/mul_unit_sim 2>&1 | tee sim.log

if grep -qF '*** PASSED ***' sim.log; then
  echo "simulation passed"
else
  echo "simulation failed"
  exit 1
fi
